/* source/cacheStore_macros.svh */
// Sizing macros for the line store, included by the package, the RTL and the testbench
`ifndef CACHESTORE_MACROS_SVH
`define CACHESTORE_MACROS_SVH

// Array geometry
`define NUM_WAYS 4
`define NUM_SETS 16
`define WAY_BITS 2
`define LINE_BITS 64
`define MASK_BITS (`LINE_BITS / 8)

// Address split is tag, set index, byte offset
`define TAG_BITS 8
`define INDEX_BITS 4
`define OFFSET_BITS 3
`define ADDR_BITS 15

// Request queue depth, also the requester's starting credits
`define REQ_DEPTH 4
`define REQ_PTR_BITS 2
`define CREDIT_BITS 8

`endif

/* source/cachePkg.sv */
// Shared opcode, state and request/response types, imported by every module that needs them
`default_nettype none

`include "cacheStore_macros.svh"

package cachePkg;

  //////////////////////////////////////////////////
  // Operations
  //////////////////////////////////////////////////

  // One operation per request
  typedef enum logic [1:0] {
    opLookup     = 2'd0,
    opWrite      = 2'd1,
    opFill       = 2'd2,
    opInvalidate = 2'd3
  } cacheOp;

  // Per-cycle phase of the controller
  // stRead is the dequeue cycle, stAct the array access cycle
  typedef enum logic [1:0] {
    stIdle = 2'd0,
    stRead = 2'd1,
    stAct  = 2'd2
  } ctrlState;

  //////////////////////////////////////////////////
  // Request and response
  //////////////////////////////////////////////////

  typedef struct packed {
    cacheOp                  op;
    logic [`ADDR_BITS-1:0]   addr;
    logic [`LINE_BITS-1:0]   data;
    // One bit per byte of the line, used by writes only
    logic [`MASK_BITS-1:0]   mask;
  } cacheReq;

  typedef struct packed {
    cacheOp                  op;
    logic                    hit;
    logic [`LINE_BITS-1:0]   data;
    // Victim fields are only meaningful for fills
    logic [`TAG_BITS-1:0]    victimTag;
    logic                    victimDirty;
  } cacheRsp;

endpackage

`default_nettype wire

/* source/wayIf.sv */
// Bundle between the controller, the way array and the combiner, one modport per role
`timescale 1ns/100ps
`default_nettype none

`include "cacheStore_macros.svh"

interface wayIf;

  // Controller to ways
  logic [`INDEX_BITS-1:0]           index;
  logic [`TAG_BITS-1:0]             tag;
  logic [`LINE_BITS-1:0]            writeData;
  logic [`MASK_BITS-1:0]            byteMask;
  // One-hot per way
  logic [`NUM_WAYS-1:0]             fillWay;
  logic [`NUM_WAYS-1:0]             writeEnable;
  logic                             invalidateAll;

  // Ways to controller and combiner, each way drives its own bit or slice
  logic [`NUM_WAYS-1:0]             hitVec;
  logic [`NUM_WAYS-1:0]             validVec;
  logic [`NUM_WAYS-1:0]             dirtyVec;
  logic [`NUM_WAYS*`LINE_BITS-1:0]  lineVec;
  logic [`NUM_WAYS*`TAG_BITS-1:0]   tagVec;

  // Controller to combiner, nonzero only in the act cycle
  logic [`NUM_WAYS-1:0]             hitSel;
  logic [`NUM_WAYS-1:0]             victimSel;

  modport control (
    output index, tag, writeData, byteMask, fillWay, writeEnable, invalidateAll,
    output hitSel, victimSel,
    input  hitVec, validVec
  );

  modport way (
    input  index, tag, writeData, byteMask, fillWay, writeEnable, invalidateAll,
    output hitVec, validVec, dirtyVec, lineVec, tagVec
  );

  modport combine (
    input  hitSel, victimSel, validVec, dirtyVec, lineVec, tagVec
  );

endinterface

`default_nettype wire

/* source/cacheWay.sv */
// One cache way with tag, data, valid and dirty storage, instantiated once per way by the top
`timescale 1ns/100ps
`default_nettype none

`include "cacheStore_macros.svh"

module cacheWay #(
  parameter int WAY_ID = 0
) (
  input logic clk,
  input logic reset,
  wayIf.way   ways
);

  // Storage arrays, one entry per set
  logic [`TAG_BITS-1:0]   tagMem [`NUM_SETS];
  logic [`LINE_BITS-1:0]  dataMem [`NUM_SETS];
  logic [`NUM_SETS-1:0]   validBits;
  logic [`NUM_SETS-1:0]   dirtyBits;

  // Registered read of the addressed set
  logic [`TAG_BITS-1:0]   readTag;
  logic [`LINE_BITS-1:0]  readLine;
  logic                   readValid;
  logic                   readDirty;

  logic [`LINE_BITS-1:0]  mergedLine;
  logic                   doFill;
  logic                   doWrite;

  // This way's slice of the one-hot enables
  assign doFill  = ways.fillWay[WAY_ID];
  assign doWrite = ways.writeEnable[WAY_ID];

  //////////////////////////////////////////////////
  // Byte merge for partial writes
  //////////////////////////////////////////////////

  // Old bytes come from the read done in the dequeue cycle
  always_comb begin
    for (int b = 0; b < `MASK_BITS; b++) begin
      mergedLine[b*8 +: 8] = ways.byteMask[b] ? ways.writeData[b*8 +: 8] : readLine[b*8 +: 8];
    end
  end

  //////////////////////////////////////////////////
  // Tag, data and dirty arrays
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    readTag   <= tagMem[ways.index];
    readLine  <= dataMem[ways.index];
    readDirty <= dirtyBits[ways.index];
    // Fill installs a whole new line
    if (doFill) begin
      tagMem[ways.index]  <= ways.tag;
      dataMem[ways.index] <= ways.writeData;
    end else if (doWrite) begin
      dataMem[ways.index] <= mergedLine;
    end
    // Fill leaves the line clean, a write marks it dirty
    if (doFill || doWrite) begin
      dirtyBits[ways.index] <= doWrite;
    end
  end

  //////////////////////////////////////////////////
  // Valid bits
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      validBits <= '0;
      readValid <= 1'b0;
    end else begin
      readValid <= validBits[ways.index];
      if (ways.invalidateAll) begin
        validBits <= '0;
      end else if (doFill) begin
        validBits[ways.index] <= 1'b1;
      end
    end
  end

  // Hit needs a live line and a matching tag
  assign ways.hitVec[WAY_ID]   = readValid && (readTag == ways.tag);
  assign ways.validVec[WAY_ID] = readValid;
  assign ways.dirtyVec[WAY_ID] = readDirty;

  // Raw slices, the combiner does the AND-OR select
  assign ways.lineVec[WAY_ID*`LINE_BITS +: `LINE_BITS] = readLine;
  assign ways.tagVec[WAY_ID*`TAG_BITS +: `TAG_BITS]    = readTag;

endmodule

`default_nettype wire

/* source/cacheControl.sv */
// Front controller with the request queue, credits, sequencing and victim choice
`timescale 1ns/100ps
`default_nettype none

`include "cacheStore_macros.svh"

module cacheControl (
  input  logic              clk,
  input  logic              reset,
  input  cachePkg::cacheReq req,
  input  logic              reqValid,
  input  logic              rspCredit,
  output logic              reqCredit,
  output cachePkg::cacheOp  rspOp,
  wayIf.control             ways
);

  import cachePkg::*;

  cacheReq                   reqFifo [`REQ_DEPTH];
  logic [`REQ_PTR_BITS-1:0]  wrPtr;
  logic [`REQ_PTR_BITS-1:0]  rdPtr;
  logic [`REQ_PTR_BITS:0]    reqCount;
  logic [`CREDIT_BITS-1:0]   rspCredits;
  cacheReq                   headReq;
  cacheReq                   curReq;
  ctrlState                  state;
  ctrlState                  phase;
  logic                      deq;
  logic                      actCycle;
  logic [`ADDR_BITS-1:0]     addrSel;
  logic [`INDEX_BITS-1:0]    curIndex;
  logic [`WAY_BITS-1:0]      rrPtr [`NUM_SETS];
  logic [`NUM_WAYS-1:0]      firstInvalid;
  logic                      anyInvalid;
  logic [`NUM_WAYS-1:0]      victimPick;
  logic                      useRr;

  //////////////////////////////////////////////////
  // Request queue and credits
  //////////////////////////////////////////////////

  // Dequeue needs a queued request, a response slot, and no access in flight
  assign deq       = (reqCount != '0) && (rspCredits != '0) && (state != stAct);
  assign reqCredit = deq;
  assign headReq   = reqFifo[rdPtr];

  always_ff @(posedge clk) begin
    if (reqValid) begin
      reqFifo[wrPtr] <= req;
    end
    if (deq) begin
      curReq <= headReq;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wrPtr      <= '0;
      rdPtr      <= '0;
      reqCount   <= '0;
      rspCredits <= '0;
    end else begin
      if (reqValid) wrPtr <= wrPtr + 1'b1;
      if (deq) rdPtr <= rdPtr + 1'b1;
      // Requester never sends without a credit, so no full check
      case ({reqValid, deq})
        2'b10:   reqCount <= reqCount + 1'b1;
        2'b01:   reqCount <= reqCount - 1'b1;
        default: reqCount <= reqCount;
      endcase
      case ({rspCredit, deq})
        2'b10:   rspCredits <= rspCredits + 1'b1;
        2'b01:   rspCredits <= rspCredits - 1'b1;
        default: rspCredits <= rspCredits;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Sequencing
  //////////////////////////////////////////////////

  // Register holds stAct for the cycle after a dequeue
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= stIdle;
    end else begin
      state <= deq ? stAct : stIdle;
    end
  end

  assign phase    = (state == stAct) ? stAct : (deq ? stRead : stIdle);
  assign actCycle = (phase == stAct);
  assign rspOp    = curReq.op;

  // Dequeue cycle addresses the arrays from the queue head
  assign addrSel    = (phase == stRead) ? headReq.addr : curReq.addr;
  assign ways.index = addrSel[`OFFSET_BITS +: `INDEX_BITS];
  assign ways.tag   = addrSel[`ADDR_BITS-1 -: `TAG_BITS];
  assign curIndex   = curReq.addr[`OFFSET_BITS +: `INDEX_BITS];

  assign ways.writeData = curReq.data;
  assign ways.byteMask  = curReq.mask;

  //////////////////////////////////////////////////
  // Victim choice
  //////////////////////////////////////////////////

  always_comb begin
    firstInvalid = '0;
    anyInvalid   = 1'b0;
    for (int w = 0; w < `NUM_WAYS; w++) begin
      if (!ways.validVec[w] && !anyInvalid) begin
        firstInvalid[w] = 1'b1;
        anyInvalid      = 1'b1;
      end
    end
    // Own tag first, then lowest invalid way, then the set's pointer
    if (|ways.hitVec) begin
      victimPick = ways.hitVec;
    end else if (anyInvalid) begin
      victimPick = firstInvalid;
    end else begin
      victimPick                  = '0;
      victimPick[rrPtr[curIndex]] = 1'b1;
    end
  end

  assign useRr = !(|ways.hitVec) && !anyInvalid;

  // Pointer moves only when it actually chose the victim
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < `NUM_SETS; s++) begin
        rrPtr[s] <= '0;
      end
    end else if (actCycle && (curReq.op == opFill) && useRr) begin
      rrPtr[curIndex] <= rrPtr[curIndex] + 1'b1;
    end
  end

  // Enables, all landing at the end of the act cycle
  assign ways.fillWay       = (actCycle && curReq.op == opFill) ? victimPick : '0;
  assign ways.writeEnable   = (actCycle && curReq.op == opWrite) ? ways.hitVec : '0;
  assign ways.invalidateAll = actCycle && (curReq.op == opInvalidate);

  // victimSel is one-hot in every act cycle, the combiner keys its valid on it
  assign ways.hitSel    = actCycle ? ways.hitVec : '0;
  assign ways.victimSel = actCycle ? victimPick : '0;

endmodule

`default_nettype wire

/* source/wayCombine.sv */
// AND-OR merge of the way outputs into the registered response of the store
`timescale 1ns/100ps
`default_nettype none

`include "cacheStore_macros.svh"

module wayCombine (
  input  logic              clk,
  input  logic              reset,
  input  cachePkg::cacheOp  op,
  wayIf.combine             ways,
  output cachePkg::cacheRsp rsp,
  output logic              rspValid
);

  import cachePkg::*;

  logic [`LINE_BITS-1:0]  hitLine;
  logic [`LINE_BITS-1:0]  victimLine;
  logic [`TAG_BITS-1:0]   victimTag;
  logic                   victimDirty;
  logic                   anyHit;
  cacheRsp                rspNext;

  //////////////////////////////////////////////////
  // AND-OR muxes across the ways
  //////////////////////////////////////////////////

  always_comb begin
    hitLine    = '0;
    victimLine = '0;
    victimTag  = '0;
    for (int w = 0; w < `NUM_WAYS; w++) begin
      // AND with the select bit, then OR into the result
      hitLine    |= ways.lineVec[w*`LINE_BITS +: `LINE_BITS] & {`LINE_BITS{ways.hitSel[w]}};
      victimLine |= ways.lineVec[w*`LINE_BITS +: `LINE_BITS] & {`LINE_BITS{ways.victimSel[w]}};
      victimTag  |= ways.tagVec[w*`TAG_BITS +: `TAG_BITS] & {`TAG_BITS{ways.victimSel[w]}};
    end
  end

  // Only a live line can be dirty
  assign victimDirty = |(ways.victimSel & ways.validVec & ways.dirtyVec);
  assign anyHit      = |ways.hitSel;

  //////////////////////////////////////////////////
  // Response fields per operation
  //////////////////////////////////////////////////

  always_comb begin
    rspNext             = '0;
    rspNext.op          = op;
    case (op)
      opLookup, opWrite: begin
        // Write reports the line as it was before the merge
        rspNext.hit  = anyHit;
        rspNext.data = hitLine;
      end
      opFill: begin
        rspNext.hit         = anyHit;
        rspNext.data        = victimLine;
        rspNext.victimTag   = victimTag;
        rspNext.victimDirty = victimDirty;
      end
      default: begin
        // Invalidate only acknowledges
        rspNext.hit = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    rsp <= rspNext;
  end

  // One pulse per act cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      rspValid <= 1'b0;
    end else begin
      rspValid <= |ways.victimSel;
    end
  end

endmodule

`default_nettype wire

/* source/cacheStore.sv */
// Top level of the line store, with plain request, credit and response ports
`timescale 1ns/100ps
`default_nettype none

`include "cacheStore_macros.svh"

module cacheStore (
  input  logic                   clk,
  input  logic                   reset,
  // Request side, one request per held credit
  input  logic                   reqValid,
  input  cachePkg::cacheOp       reqOp,
  input  logic [`ADDR_BITS-1:0]  reqAddr,
  input  logic [`LINE_BITS-1:0]  reqData,
  input  logic [`MASK_BITS-1:0]  reqMask,
  output logic                   reqCredit,
  // Response side, one slot per rspCredit pulse
  input  logic                   rspCredit,
  output logic                   rspValid,
  output cachePkg::cacheOp       rspOp,
  output logic                   rspHit,
  output logic [`LINE_BITS-1:0]  rspData,
  output logic [`TAG_BITS-1:0]   rspVictimTag,
  output logic                   rspVictimDirty
);

  import cachePkg::*;

  cacheReq  req;
  cacheRsp  rsp;
  cacheOp   curOp;

  wayIf ways ();

  assign req = '{op: reqOp, addr: reqAddr, data: reqData, mask: reqMask};

  cacheControl control_i (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .reqValid  (reqValid),
    .rspCredit (rspCredit),
    .reqCredit (reqCredit),
    .rspOp     (curOp),
    .ways      (ways.control)
  );

  // One way per generate copy, each driving its own slice
  for (genvar w = 0; w < `NUM_WAYS; w++) begin : gWay
    cacheWay #(.WAY_ID(w)) way_i (
      .clk   (clk),
      .reset (reset),
      .ways  (ways.way)
    );
  end

  wayCombine combine_i (
    .clk      (clk),
    .reset    (reset),
    .op       (curOp),
    .ways     (ways.combine),
    .rsp      (rsp),
    .rspValid (rspValid)
  );

  assign rspOp          = rsp.op;
  assign rspHit         = rsp.hit;
  assign rspData        = rsp.data;
  assign rspVictimTag   = rsp.victimTag;
  assign rspVictimDirty = rsp.victimDirty;

endmodule

`default_nettype wire

/* tests/cacheStoreTbTable.svh */
// Request and expected-response table, included inside the testbench module body
`ifndef CACHESTORE_TB_TABLE_SVH
`define CACHESTORE_TB_TABLE_SVH

// Columns, first line: op, tag, set, line data, byte mask, held back
// Columns, second line: hit, check data, data, victim tag, victim dirty
task automatic loadTable();
  // Cold lookup, then fill and hit
  addRow(opLookup, 8'h11, 4'h2, 64'h0, 8'h00, 1'b0,
         1'b0, 1'b0, 64'h0, 8'h00, 1'b0);
  addRow(opFill, 8'h11, 4'h2, 64'h0123_4567_89ab_cdef, 8'h00, 1'b0,
         1'b0, 1'b0, 64'h0, 8'h00, 1'b0);
  addRow(opLookup, 8'h11, 4'h2, 64'h0, 8'h00, 1'b0,
         1'b1, 1'b1, 64'h0123_4567_89ab_cdef, 8'h00, 1'b0);

  // Masked write on a hit, low four bytes only
  addRow(opWrite, 8'h11, 4'h2, 64'hffee_ddcc_bbaa_9988, 8'h0f, 1'b0,
         1'b1, 1'b0, 64'h0, 8'h00, 1'b0);
  addRow(opLookup, 8'h11, 4'h2, 64'h0, 8'h00, 1'b0,
         1'b1, 1'b1, 64'h0123_4567_bbaa_9988, 8'h00, 1'b0);
  // Write miss must not touch the set
  addRow(opWrite, 8'h22, 4'h2, 64'hdead_beef_dead_beef, 8'hff, 1'b0,
         1'b0, 1'b0, 64'h0, 8'h00, 1'b0);
  addRow(opLookup, 8'h11, 4'h2, 64'h0, 8'h00, 1'b0,
         1'b1, 1'b1, 64'h0123_4567_bbaa_9988, 8'h00, 1'b0);

  // Four fills take the empty ways of set 5
  addRow(opFill, 8'h51, 4'h5, 64'h1111_1111_1111_1111, 8'h00, 1'b0,
         1'b0, 1'b0, 64'h0, 8'h00, 1'b0);
  addRow(opFill, 8'h52, 4'h5, 64'h2222_2222_2222_2222, 8'h00, 1'b0,
         1'b0, 1'b0, 64'h0, 8'h00, 1'b0);
  addRow(opFill, 8'h53, 4'h5, 64'h3333_3333_3333_3333, 8'h00, 1'b0,
         1'b0, 1'b0, 64'h0, 8'h00, 1'b0);
  addRow(opFill, 8'h54, 4'h5, 64'h4444_4444_4444_4444, 8'h00, 1'b0,
         1'b0, 1'b0, 64'h0, 8'h00, 1'b0);
  // Dirty the way 0 line, upper bytes
  addRow(opWrite, 8'h51, 4'h5, 64'haaaa_aaaa_aaaa_aaaa, 8'hf0, 1'b0,
         1'b1, 1'b0, 64'h0, 8'h00, 1'b0);
  // Full set, pointer at way 0 then way 1
  addRow(opFill, 8'h55, 4'h5, 64'h5555_5555_5555_5555, 8'h00, 1'b0,
         1'b0, 1'b1, 64'haaaa_aaaa_1111_1111, 8'h51, 1'b1);
  addRow(opFill, 8'h56, 4'h5, 64'h6666_6666_6666_6666, 8'h00, 1'b0,
         1'b0, 1'b1, 64'h2222_2222_2222_2222, 8'h52, 1'b0);
  addRow(opLookup, 8'h51, 4'h5, 64'h0, 8'h00, 1'b0,
         1'b0, 1'b0, 64'h0, 8'h00, 1'b0);
  // Fill of a resident tag reuses its own way
  addRow(opFill, 8'h55, 4'h5, 64'h7777_7777_7777_7777, 8'h00, 1'b0,
         1'b1, 1'b1, 64'h5555_5555_5555_5555, 8'h55, 1'b0);

  // Invalidate everything, old lines miss, stale dirty bit is hidden
  addRow(opInvalidate, 8'h00, 4'h0, 64'h0, 8'h00, 1'b0,
         1'b0, 1'b0, 64'h0, 8'h00, 1'b0);
  addRow(opLookup, 8'h11, 4'h2, 64'h0, 8'h00, 1'b0,
         1'b0, 1'b0, 64'h0, 8'h00, 1'b0);
  addRow(opLookup, 8'h55, 4'h5, 64'h0, 8'h00, 1'b0,
         1'b0, 1'b0, 64'h0, 8'h00, 1'b0);
  addRow(opFill, 8'h61, 4'h2, 64'h0f1e_2d3c_4b5a_6978, 8'h00, 1'b0,
         1'b0, 1'b0, 64'h0, 8'h00, 1'b0);

  // Queued under back-pressure, answered in order once released
  addRow(opLookup, 8'h61, 4'h2, 64'h0, 8'h00, 1'b1,
         1'b1, 1'b1, 64'h0f1e_2d3c_4b5a_6978, 8'h00, 1'b0);
  addRow(opWrite, 8'h61, 4'h2, 64'hc0c0_c0c0_c0c0_c0c0, 8'h81, 1'b1,
         1'b1, 1'b0, 64'h0, 8'h00, 1'b0);
  addRow(opLookup, 8'h61, 4'h2, 64'h0, 8'h00, 1'b1,
         1'b1, 1'b1, 64'hc01e_2d3c_4b5a_69c0, 8'h00, 1'b0);
  addRow(opLookup, 8'h11, 4'h2, 64'h0, 8'h00, 1'b1,
         1'b0, 1'b0, 64'h0, 8'h00, 1'b0);
endtask

`endif

/* tests/cacheStoreTb.sv */
// Self-checking testbench for the line store, compiled from cacheStore.f and run by run.sh
`timescale 1ns/100ps
`default_nettype none

`include "cacheStore_macros.svh"

module cacheStoreTb;

  import cachePkg::*;

  // Wait limits in clock cycles
  localparam int TIMEOUT_CYCLES = 40;
  localparam int HOLD_CYCLES    = 12;

  // One request and the response it must produce
  typedef struct {
    cacheOp                 op;
    logic [`ADDR_BITS-1:0]  addr;
    logic [`LINE_BITS-1:0]  data;
    logic [`MASK_BITS-1:0]  mask;
    bit                     held;
    bit                     expHit;
    bit                     checkData;
    logic [`LINE_BITS-1:0]  expData;
    logic [`TAG_BITS-1:0]   expTag;
    bit                     expDirty;
  } tableRow;

  logic                   clk;
  logic                   reset;
  logic                   reqValid;
  cacheOp                 reqOp;
  logic [`ADDR_BITS-1:0]  reqAddr;
  logic [`LINE_BITS-1:0]  reqData;
  logic [`MASK_BITS-1:0]  reqMask;
  logic                   reqCredit;
  logic                   rspCredit;
  logic                   rspValid;
  cacheOp                 rspOp;
  logic                   rspHit;
  logic [`LINE_BITS-1:0]  rspData;
  logic [`TAG_BITS-1:0]   rspVictimTag;
  logic                   rspVictimDirty;

  tableRow rows[$];
  // Requests sent, request credits handed back, responses seen
  int sent     = 0;
  int returned = 0;
  int received = 0;

  cacheStore cacheStore_i (.*);

  // 40 ns clock
  initial clk = 1'b0;
  always #20 clk = ~clk;

  //////////////////////////////////////////////////
  // Reporting
  //////////////////////////////////////////////////

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkValue(input string name, input logic [63:0] actual,
                            input logic [63:0] expected);
    if (actual !== expected) begin
      abortRun($sformatf("[FAIL] time %0t %s: got %0h, expected %0h",
                         $time, name, actual, expected));
    end
  endtask

  //////////////////////////////////////////////////
  // Table
  //////////////////////////////////////////////////

  task automatic addRow(input cacheOp op, input logic [`TAG_BITS-1:0] tag,
                        input logic [`INDEX_BITS-1:0] set, input logic [`LINE_BITS-1:0] data,
                        input logic [`MASK_BITS-1:0] mask, input bit held, input bit expHit,
                        input bit checkData, input logic [`LINE_BITS-1:0] expData,
                        input logic [`TAG_BITS-1:0] expTag, input bit expDirty);
    tableRow row;
    row.op        = op;
    // Line aligned with a zero byte offset
    row.addr      = {tag, set, {`OFFSET_BITS{1'b0}}};
    row.data      = data;
    row.mask      = mask;
    row.held      = held;
    row.expHit    = expHit;
    row.checkData = checkData;
    row.expData   = expData;
    row.expTag    = expTag;
    row.expDirty  = expDirty;
    rows.push_back(row);
  endtask

  `include "cacheStoreTbTable.svh"

  //////////////////////////////////////////////////
  // Requester and consumer
  //////////////////////////////////////////////////

  // All tasks start and end 1 ns after a rising edge
  task automatic sendRequest(input tableRow row);
    int waited;
    waited = 0;
    // Spend a credit only when one is held
    while (sent - returned >= `REQ_DEPTH) begin
      if (waited == TIMEOUT_CYCLES) begin
        abortRun("Timed out waiting for a request credit");
      end else begin
        @(posedge clk);
        #1;
        waited++;
      end
    end
    reqValid = 1'b1;
    reqOp    = row.op;
    reqAddr  = row.addr;
    reqData  = row.data;
    reqMask  = row.mask;
    sent++;
    @(posedge clk);
    #1;
    reqValid = 1'b0;
  endtask

  task automatic grantCredits(input int count);
    repeat (count) begin
      rspCredit = 1'b1;
      @(posedge clk);
      #1;
      rspCredit = 1'b0;
      @(posedge clk);
      #1;
    end
  endtask

  task automatic waitResponses(input int target);
    int waited;
    waited = 0;
    while (received < target) begin
      if (waited == TIMEOUT_CYCLES) begin
        abortRun("Timed out waiting for rspValid");
      end else begin
        @(posedge clk);
        #1;
        waited++;
      end
    end
  endtask

  // Queue stays put without response credits and then drains in order
  task automatic holdAndRelease();
    int quietReceived;
    int quietReturned;
    quietReceived = received;
    quietReturned = returned;
    repeat (HOLD_CYCLES) @(posedge clk);
    #1;
    checkValue("responses while held", 64'(received), 64'(quietReceived));
    checkValue("reqCredit pulses while held", 64'(returned), 64'(quietReturned));
    checkValue("request credits owed", 64'(sent - returned), 64'(sent - received));
    grantCredits(sent - received);
    waitResponses(sent);
  endtask

  task automatic checkResponse(input int idx);
    tableRow row;
    row = rows[idx];
    checkValue("rspOp", 64'(rspOp), 64'(row.op));
    checkValue("rspHit", 64'(rspHit), 64'(row.expHit));
    if (row.checkData) begin
      checkValue("rspData", rspData, row.expData);
    end
    // Victim fields matter for fills only
    if (row.op == opFill) begin
      if (row.checkData) begin
        checkValue("rspVictimTag", 64'(rspVictimTag), 64'(row.expTag));
      end
      checkValue("rspVictimDirty", 64'(rspVictimDirty), 64'(row.expDirty));
    end
  endtask

  //////////////////////////////////////////////////
  // Monitor and main sequence
  //////////////////////////////////////////////////

  // Sampled at the rising edge before the DUT updates
  always @(posedge clk) begin
    if (!reset) begin
      if (reqCredit) begin
        returned++;
        if (returned > sent) begin
          abortRun("reqCredit pulsed with no request queued");
        end
      end
      if (rspValid) begin
        if (received >= sent) begin
          abortRun("rspValid pulsed with no request outstanding");
        end else begin
          checkResponse(received);
          received++;
        end
      end
    end
  end

  initial begin
    reset     = 1'b1;
    reqValid  = 1'b0;
    reqOp     = opLookup;
    reqAddr   = '0;
    reqData   = '0;
    reqMask   = '0;
    rspCredit = 1'b0;
    loadTable();
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int i = 0; i < rows.size(); i++) begin
      sendRequest(rows[i]);
      if (!rows[i].held) begin
        grantCredits(1);
        waitResponses(sent);
      end else if (i == rows.size() - 1 || !rows[i + 1].held) begin
        // Last of a held group
        holdAndRelease();
      end
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* cacheStore.f */
+incdir+source
+incdir+tests
source/cachePkg.sv
source/wayIf.sv
source/cacheWay.sv
source/cacheControl.sv
source/wayCombine.sv
source/cacheStore.sv
tests/cacheStoreTb.sv

/* run.sh */
#!/bin/sh
# Build the line store testbench with Verilator, run it, then check the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG_FILE="$BUILD_DIR/sim.log"

mkdir -p "$BUILD_DIR"
if [ $? -ne 0 ]; then
  echo "Could not create the build directory"
  exit 1
fi

verilator --binary --timing -Wno-fatal --top-module cacheStoreTb \
  --Mdir "$BUILD_DIR/obj" -o cacheStoreSim -f cacheStore.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"$BUILD_DIR/obj/cacheStoreSim" > "$LOG_FILE" 2>&1
simStatus=$?
cat "$LOG_FILE"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' "$LOG_FILE"; then
  exit 0
fi
echo "Pass line not found in $LOG_FILE"
exit 1
